// ==== rtl/i2c_consts.svh ====
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

// clk cycles per quarter of an SCL period, so one bit slot is four quarters
`define I2C_QUARTER_CYCLES 5

// Field widths on the host side
`define I2C_ADDR_BITS 7
`define I2C_DATA_BITS 8

`endif

// ==== rtl/i2c_pkg.sv ====
`include "i2c_consts.svh"

package i2c_pkg;

    typedef logic [`I2C_ADDR_BITS-1:0] i2c_addr_t;    // 7-bit slave address
    typedef logic [`I2C_DATA_BITS-1:0] i2c_data_t;    // Write or read byte
    typedef logic [3:0]                i2c_bitcnt_t;  // Bit position in a byte
    typedef logic [1:0]                i2c_quarter_t; // SCL quarter 0..3

    // Byte engine states, one per bus slot type
    typedef enum logic [3:0] {
        IDLE,
        START,
        ADDR,
        ADDR_ACK,
        WRITE,
        WRITE_ACK,
        READ,
        READ_NACK,
        STOP,
        DONE
    } i2c_state_t;

endpackage

// ==== rtl/i2c_phase_if.sv ====
`timescale 1ns/1ps

// SCL phase information from the timing generator to the byte engine
interface i2c_phase_if ();

    logic run;           // Engine wants SCL running
    logic scl_high;      // Wanted SCL level
    logic tick_change;   // Middle of the low half
    logic tick_sample;   // Middle of the high half
    logic tick_slot_end; // Last cycle of the bit slot

    modport gen (
        input  run,
        output scl_high,
        output tick_change,
        output tick_sample,
        output tick_slot_end
    );

    modport eng (
        output run,
        input  scl_high,
        input  tick_change,
        input  tick_sample,
        input  tick_slot_end
    );

endinterface

// ==== rtl/i2c_scl_gen.sv ====
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_scl_gen
    import i2c_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    i2c_phase_if.gen ph
);

    // Wide enough for the quarter length, at least one bit
    localparam int QCNT_W = $clog2(`I2C_QUARTER_CYCLES + 1);

    logic [QCNT_W-1:0] qcnt;
    i2c_quarter_t      quarter;
    logic              q_end;

    assign q_end = (qcnt == QCNT_W'(`I2C_QUARTER_CYCLES - 1));

    // Quarter counter and quarter index, parked at zero while stopped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            qcnt    <= '0;
            quarter <= '0;
        end else if (!ph.run) begin
            qcnt    <= '0;
            quarter <= '0;
        end else if (q_end) begin
            qcnt    <= '0;
            quarter <= quarter + 2'd1; // Wraps into the next slot
        end else begin
            qcnt <= qcnt + 1'b1;
        end
    end

    // Quarters 0 and 1 low, 2 and 3 high
    assign ph.scl_high = quarter[1];

    // Strobes at the ends of quarters 0, 2 and 3
    assign ph.tick_change   = ph.run && q_end && (quarter == 2'd0);
    assign ph.tick_sample   = ph.run && q_end && (quarter == 2'd2);
    assign ph.tick_slot_end = ph.run && q_end && (quarter == 2'd3);

endmodule

// ==== rtl/i2c_byte_engine.sv ====
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_byte_engine
    import i2c_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    i2c_phase_if.eng  ph,
    input  logic      req,
    input  logic      rw,
    input  i2c_addr_t addr,
    input  i2c_data_t wdata,
    output logic      ack,
    output i2c_data_t rdata,
    output logic      nack,
    output logic      sda_pull,
    input  logic      sda_in
);

    localparam i2c_bitcnt_t LAST_BIT = i2c_bitcnt_t'(`I2C_DATA_BITS - 1);
    localparam int          MSB      = `I2C_DATA_BITS - 1;

    i2c_state_t  state;
    i2c_bitcnt_t bitcnt;
    i2c_data_t   shreg;   // Address+rw, then write byte or read byte
    i2c_data_t   wdata_q;
    logic        rw_q;
    logic        start_req;
    logic        shift_out;
    logic        shift_in;

    // New request only once the previous ack has been dropped
    assign start_req = (state == IDLE) && req && !ack;

    assign shift_out = ph.tick_change && ((state == ADDR) || (state == WRITE));
    assign shift_in  = ph.tick_sample && (state == READ);

    // SCL runs for every slot between IDLE and DONE
    assign ph.run = (state != IDLE) && (state != DONE);

    // Transaction FSM, advancing on slot ends
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            bitcnt   <= '0;
            rw_q     <= 1'b0;
            ack      <= 1'b0;
            nack     <= 1'b0;
            sda_pull <= 1'b0;
            rdata    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_req) begin
                        rw_q  <= rw;
                        nack  <= 1'b0;
                        state <= START;
                    end
                end

                START: begin
                    // SDA falls while SCL is high
                    if (ph.tick_sample)
                        sda_pull <= 1'b1;
                    if (ph.tick_slot_end) begin
                        bitcnt <= LAST_BIT;
                        state  <= ADDR;
                    end
                end

                ADDR, WRITE: begin
                    if (ph.tick_change)
                        sda_pull <= ~shreg[MSB]; // Pull low for a zero bit
                    if (ph.tick_slot_end) begin
                        if (bitcnt == '0)
                            state <= (state == ADDR) ? ADDR_ACK : WRITE_ACK;
                        else
                            bitcnt <= bitcnt - 1'b1;
                    end
                end

                ADDR_ACK, WRITE_ACK: begin
                    if (ph.tick_change)
                        sda_pull <= 1'b0;        // Let the slave answer
                    if (ph.tick_sample && sda_in)
                        nack <= 1'b1;            // No acknowledge seen
                    if (ph.tick_slot_end) begin
                        bitcnt <= LAST_BIT;
                        // A missed address ack skips the data byte
                        if ((state == WRITE_ACK) || nack)
                            state <= STOP;
                        else if (rw_q)
                            state <= READ;
                        else
                            state <= WRITE;
                    end
                end

                READ: begin
                    if (ph.tick_change)
                        sda_pull <= 1'b0;
                    if (ph.tick_slot_end) begin
                        if (bitcnt == '0) begin
                            rdata <= shreg;      // All bits already shifted in
                            state <= READ_NACK;
                        end else begin
                            bitcnt <= bitcnt - 1'b1;
                        end
                    end
                end

                READ_NACK: begin
                    // Single byte read, so SDA stays released as NACK
                    if (ph.tick_change)
                        sda_pull <= 1'b0;
                    if (ph.tick_slot_end)
                        state <= STOP;
                end

                STOP: begin
                    if (ph.tick_change)
                        sda_pull <= 1'b1;        // Low before SCL rises
                    if (ph.tick_sample)
                        sda_pull <= 1'b0;        // SDA rises while SCL is high
                    if (ph.tick_slot_end) begin
                        ack   <= 1'b1;
                        state <= DONE;
                    end
                end

                DONE: begin
                    // Hold ack until the host lets go of req
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // Shift register and captured write byte
    always_ff @(posedge clk) begin
        if (start_req) begin
            shreg   <= {addr, rw};
            wdata_q <= wdata;
        end else if (shift_out) begin
            shreg <= {shreg[MSB-1:0], 1'b0};
        end else if (shift_in) begin
            shreg <= {shreg[MSB-1:0], sda_in}; // MSB first
        end else if (ph.tick_slot_end && (state == ADDR_ACK)) begin
            shreg <= wdata_q;
        end
    end

endmodule

// ==== rtl/i2c_master_top.sv ====
`timescale 1ns/1ps

module i2c_master_top
    import i2c_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // Host side
    input  logic      req,
    input  logic      rw,
    input  i2c_addr_t addr,
    input  i2c_data_t wdata,
    output logic      ack,
    output i2c_data_t rdata,
    output logic      nack,
    // Bus side, 1 on a pull means drive low
    output logic      scl_pull,
    input  logic      scl_in,   // Observation only, no clock stretching
    output logic      sda_pull,
    input  logic      sda_in
);

    i2c_phase_if ph ();

    i2c_scl_gen i2c_scl_gen_i (
        .clk (clk),
        .rst (rst),
        .ph  (ph)
    );

    i2c_byte_engine i2c_byte_engine_i (
        .clk      (clk),
        .rst      (rst),
        .ph       (ph),
        .req      (req),
        .rw       (rw),
        .addr     (addr),
        .wdata    (wdata),
        .ack      (ack),
        .rdata    (rdata),
        .nack     (nack),
        .sda_pull (sda_pull),
        .sda_in   (sda_in)
    );

    // SCL released whenever the engine is not running
    assign scl_pull = ph.run & ~ph.scl_high;

endmodule

// ==== verif/i2c_slave_model.sv ====
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_slave_model
    import i2c_pkg::*;
#(
    parameter i2c_addr_t ADDR = 7'h2A
) (
    input  logic      scl,
    input  logic      sda,
    output logic      sda_pull,
    output i2c_data_t stored,      // The single data register
    output int        start_count,
    output int        stop_count
);

    i2c_data_t shift;
    int        starts = 0;
    int        stops  = 0;
    event      start_seen;

    assign start_count = starts;
    assign stop_count  = stops;

    // Start and stop are SDA edges while SCL is high
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            starts = starts + 1;
            -> start_seen;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1)
            stops = stops + 1;
    end

    task automatic receive_byte(output i2c_data_t b);
        b = '0;
        for (int i = 0; i < `I2C_DATA_BITS; i++) begin
            @(posedge scl);
            b = {b[`I2C_DATA_BITS-2:0], sda}; // MSB first
        end
    endtask

    // Holds SDA low through the acknowledge slot, caller decides what follows
    task automatic drive_ack();
        @(negedge scl);
        sda_pull = 1'b1;
        @(negedge scl);
    endtask

    initial begin
        sda_pull = 1'b0;
        stored   = 8'hA5;
        forever begin
            @(start_seen);
            receive_byte(shift);
            if (shift[`I2C_DATA_BITS-1:1] == ADDR) begin
                drive_ack();
                if (shift[0]) begin
                    for (int i = `I2C_DATA_BITS - 1; i >= 0; i--) begin
                        sda_pull = ~stored[i];
                        @(negedge scl);
                    end
                    sda_pull = 1'b0;  // SDA left to the master for its NACK
                end else begin
                    sda_pull = 1'b0;
                    receive_byte(shift);
                    stored = shift;
                    drive_ack();
                    sda_pull = 1'b0;
                end
            end
        end
    end

endmodule

// ==== verif/i2c_master_properties.sv ====
`timescale 1ns/1ps

module i2c_master_properties
    import i2c_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       req,
    input logic       ack,
    input logic       scl_pull,
    input logic       sda_pull,
    input i2c_state_t state
);

    int unsigned assert_errors = 0;

    // Four-phase handshake
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> req)
    else begin
        assert_errors++;
        $error("ack rose while req was low");
    end

    ack_falls_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> $past(!req))
    else begin
        assert_errors++;
        $error("ack fell while req was still high");
    end

    // With SCL high, SDA may only move for start and stop
    sda_stable_in_high: assert property (@(posedge clk) disable iff (rst)
        ($changed(sda_pull) && !scl_pull) |-> (state inside {START, STOP}))
    else begin
        assert_errors++;
        $error("sda_pull changed while SCL was high outside start/stop");
    end

    idle_released: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE) |-> (!scl_pull && !sda_pull))
    else begin
        assert_errors++;
        $error("bus pulled low while the engine was idle");
    end

endmodule

bind i2c_master_top i2c_master_properties i2c_master_properties_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .ack      (ack),
    .scl_pull (scl_pull),
    .sda_pull (sda_pull),
    .state    (i2c_byte_engine_i.state)
);

// ==== verif/i2c_master_tb.sv ====
`timescale 1ns/1ps
`include "i2c_consts.svh"

module i2c_master_tb
    import i2c_pkg::*;
();

    localparam int        CLK_PERIOD   = 40;
    localparam int        SLOT_CYCLES  = 4 * `I2C_QUARTER_CYCLES;
    localparam int        NUM_RANDOM   = 200;
    localparam int        NUM_DIRECTED = 6;
    localparam int        ACK_LIMIT    = 21 * SLOT_CYCLES + 20;
    localparam longint    WATCHDOG_NS  = longint'(NUM_RANDOM + NUM_DIRECTED)
                                         * (21 * SLOT_CYCLES + 40) * CLK_PERIOD
                                         + 2000 * CLK_PERIOD;
    localparam i2c_addr_t SLAVE_ADDR   = 7'h2A;

    logic        clk;
    logic        rst;
    logic        req;
    logic        rw;
    i2c_addr_t   addr;
    i2c_data_t   wdata;
    logic        ack;
    i2c_data_t   rdata;
    logic        nack;
    logic        scl_pull;
    logic        sda_pull;
    logic        slave_sda_pull;
    logic        scl;
    logic        sda;
    i2c_data_t   slave_data;
    int          slave_starts;
    int          slave_stops;
    logic [15:0] lfsr_q;
    i2c_data_t   model_reg;      // Copy of the slave register
    int          errors;
    int          issued;

    // Wired-AND bus, high unless pulled
    assign scl = !scl_pull;
    assign sda = !(sda_pull || slave_sda_pull);

    i2c_master_top i2c_master_top_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .rw       (rw),
        .addr     (addr),
        .wdata    (wdata),
        .ack      (ack),
        .rdata    (rdata),
        .nack     (nack),
        .scl_pull (scl_pull),
        .scl_in   (scl),
        .sda_pull (sda_pull),
        .sda_in   (sda)
    );

    i2c_slave_model #(.ADDR(SLAVE_ADDR)) i2c_slave_model_i (
        .scl         (scl),
        .sda         (sda),
        .sda_pull    (slave_sda_pull),
        .stored      (slave_data),
        .start_count (slave_starts),
        .stop_count  (slave_stops)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_next_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_next_bit()};
        return v;
    endfunction

    task automatic check_data(input i2c_data_t got, input i2c_data_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at time %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_nack(input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at time %0t: nack is %0b, expected %0b", $time, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at time %0t: %0d %s, expected %0d", $time, got, what, exp);
        end
    endtask

    task automatic wait_ack(input logic level, output logic ok);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < ACK_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        ok = (ack === level);
        if (!ok) begin
            errors++;
            $display("Handshake stalled: ack never went to %0b (time %0t)", level, $time);
        end
    endtask

    task automatic run_transaction(input i2c_addr_t a, input logic r, input i2c_data_t d);
        logic      hit;
        logic      ok;
        i2c_data_t exp_rdata;
        int        hold;
        hit       = (a == SLAVE_ADDR);
        exp_rdata = model_reg;
        if (hit && !r)
            model_reg = d;
        if (scl !== 1'b1 || sda !== 1'b1) begin
            errors++;
            $display("Bus not idle before transaction %0d (time %0t)", issued, $time);
        end
        @(posedge clk);
        req   <= 1'b1;
        rw    <= r;
        addr  <= a;
        wdata <= d;
        issued++;
        wait_ack(1'b1, ok);
        if (ok) begin
            check_nack(nack, !hit);
            if (hit && r)
                check_data(rdata, exp_rdata, "rdata");
            hold = int'(random_bits(4)); // Host keeps req up a little longer
            repeat (hold) begin
                @(posedge clk);
                if (ack !== 1'b1) begin
                    errors++;
                    $display("FAILED at time %0t: ack dropped while req was high", $time);
                end
            end
        end
        req <= 1'b0;
        wait_ack(1'b0, ok);
        check_data(slave_data, model_reg, "slave register");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the simulation ran out of time");
        $display("Regression failed");
        $finish;
    end

    initial begin
        i2c_addr_t   a;
        logic        r;
        i2c_data_t   d;
        int unsigned assert_errors;
        int          start_base;
        int          stop_base;
        rst       = 1'b1;
        req       = 1'b0;
        rw        = 1'b0;
        addr      = '0;
        wdata     = '0;
        lfsr_q    = 16'd65;
        model_reg = 8'hA5;
        errors    = 0;
        issued    = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        // Bus lines settling out of reset are not transactions
        start_base = slave_starts;
        stop_base  = slave_stops;

        run_transaction(SLAVE_ADDR, 1'b1, 8'h00);  // Reset value
        run_transaction(SLAVE_ADDR, 1'b0, 8'h3C);
        run_transaction(SLAVE_ADDR, 1'b1, 8'h00);
        // Unknown addresses are not acknowledged
        run_transaction(7'h15, 1'b0, 8'hFF);
        run_transaction(7'h2B, 1'b1, 8'h00);
        run_transaction(SLAVE_ADDR, 1'b1, 8'h00);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = lfsr_next_bit() ? SLAVE_ADDR : i2c_addr_t'(random_bits(`I2C_ADDR_BITS));
            r = lfsr_next_bit();
            d = i2c_data_t'(random_bits(`I2C_DATA_BITS));
            run_transaction(a, r, d);
        end

        repeat (4) @(posedge clk);
        check_count(slave_starts - start_base, issued, "start conditions");
        check_count(slave_stops - stop_base, issued, "stop conditions");

        assert_errors = i2c_master_top_i.i2c_master_properties_i.assert_errors;
        $display("Errors: %0d check, %0d assertion", errors, assert_errors);
        if (errors == 0 && assert_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/i2c_pkg.sv
rtl/i2c_phase_if.sv
rtl/i2c_scl_gen.sv
rtl/i2c_byte_engine.sv
rtl/i2c_master_top.sv
verif/i2c_slave_model.sv
verif/i2c_master_properties.sv
verif/i2c_master_tb.sv
